// File: sim.f
sonic_pkg.sv
sonic_gearbox_40_66.sv
sonic_blocksync.sv
sonic_rx_ring.sv
sonic_rx_chan_66.sv
sonic_rx_chan_properties.sv
tb_sonic_rx_chan.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the receive channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_sonic_rx_chan -o tb_sim
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
   exit 0
fi
exit 1

// File: tb_sonic_rx_chan.sv
// Testbench for the receive channel with stream generator, reference model, reader and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_sonic_rx_chan
   import sonic_pkg::*;
();

   localparam logic [31:0] lfsr_seed   = 32'hd0d81873;
   // Galois taps for x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] lfsr_taps   = 32'h80200003;
   localparam int          junk_bits   = 23;
   localparam int          max_blocks  = 2400;
   localparam int          stream_words = (junk_bits + max_blocks * block_width) / xcvr_width;
   localparam int          watchdog_ns = stream_words * 40 + 20000;

   logic                       wr_clock;
   logic                       rd_clock;
   logic                       rst_n;
   logic [xcvr_width-1:0]      data_in;
   logic [ring_addr_width-1:0] rd_address;
   logic                       enable_sfp;
   logic                       xcvr_rx_ready;
   logic                       dma_rdreq;
   logic [ring_width-1:0]      data_out;
   logic [ring_ptr_width-1:0]  rx_ring_wptr;

   // Stimulus state
   logic [31:0]                lfsr_state;
   logic                       stream_bits[$];
   logic [payload_width-1:0]   sent_q[$];
   int                         block_cnt;
   int                         inject_start;

   // Reader and checker state
   bit                         reads_allowed;
   bit                         resync;
   bit                         have_prev;
   bit                         wrap_seen;
   bit                         pending;
   int                         prev_idx;
   int                         jump_count;
   int                         words_read;
   logic [ring_ptr_width-1:0]  rd_ptr;
   logic [ring_width-1:0]      last_data;
   logic [ring_ptr_width-1:0]  frozen_wptr;

   sonic_rx_chan_66 dut (
      .data_in       (data_in),
      .wr_clock      (wr_clock),
      .rd_clock      (rd_clock),
      .rst_n         (rst_n),
      .rd_address    (rd_address),
      .enable_sfp    (enable_sfp),
      .xcvr_rx_ready (xcvr_rx_ready),
      .dma_rdreq     (dma_rdreq),
      .data_out      (data_out),
      .rx_ring_wptr  (rx_ring_wptr)
   );

   // 10 ns write clock and 14 ns read clock
   initial begin
      wr_clock = 1'b0;
      forever #5 wr_clock = ~wr_clock;
   end

   initial begin
      rd_clock = 1'b0;
      forever #7 rd_clock = ~rd_clock;
   end

   // One Galois step per random bit
   function automatic logic take_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
      return b;
   endfunction

   // Ring word from two consecutive payloads with the earlier one low
   function automatic logic [ring_width-1:0] ring_word_ref(
      input logic [payload_width-1:0] first,
      input logic [payload_width-1:0] second
   );
      return {second, first};
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "Check failed");
   endtask

   // Next 66-bit block onto the serial stream with the header first
   task automatic append_block();
      logic [1:0]               header;
      logic [payload_width-1:0] payload;
      int                       rel;
      for (int i = 0; i < payload_width; i++) begin
         payload[i] = take_bit();
      end
      rel = block_cnt - inject_start;
      if (rel >= 0 && rel < unlock_window && rel % 2 == 1) begin
         // Bad header on every other block of the stretch
         header = 2'b00;
      end else if ((block_cnt / 48) % 4 == 3) begin
         header = 2'b10;
      end else begin
         header = 2'b01;
      end
      stream_bits.push_back(header[0]);
      stream_bits.push_back(header[1]);
      for (int i = 0; i < payload_width; i++) begin
         stream_bits.push_back(payload[i]);
      end
      sent_q.push_back(payload);
      block_cnt++;
   endtask

   // Locate or predict the ring word just read
   task automatic check_word(input logic [ring_width-1:0] got);
      int                    idx;
      int                    start;
      bit                    found;
      logic [ring_width-1:0] expected;
      found = 1'b0;
      idx   = 0;
      if (!have_prev || resync) begin
         // After a gap the next word may start anywhere later
         start = have_prev ? prev_idx + 2 : 0;
         for (int i = start; i + 1 < sent_q.size(); i++) begin
            if (ring_word_ref(sent_q[i], sent_q[i+1]) == got) begin
               found = 1'b1;
               idx   = i;
               break;
            end
         end
         assert (found) else report_failure("Ring word matches no later pair of sent payloads");
         if (have_prev && idx != prev_idx + 2) begin
            jump_count++;
            resync = 1'b0;
         end
      end else begin
         idx = prev_idx + 2;
         assert (idx + 1 < sent_q.size())
            else report_failure("Ring word read ahead of the sent stream");
         expected = ring_word_ref(sent_q[idx], sent_q[idx+1]);
         assert (got == expected)
            else report_failure($sformatf("[ERROR] data_out got %h expected %h", got, expected));
      end
      prev_idx  = idx;
      have_prev = 1'b1;
      words_read++;
   endtask

   // Serializer sends one 40-bit word per write clock
   initial begin
      logic [xcvr_width-1:0] word;
      wait (rst_n === 1'b1);
      forever begin
         @(posedge wr_clock);
         #1;
         while (stream_bits.size() < xcvr_width) begin
            append_block();
         end
         for (int i = 0; i < xcvr_width; i++) begin
            word[i] = stream_bits.pop_front();
         end
         data_in = word;
      end
   end

   // DMA-style reader with at most one read per rd_clock
   initial begin
      wait (rst_n === 1'b1);
      forever begin
         @(posedge rd_clock);
         #1;
         if (pending) begin
            check_word(data_out);
            pending = 1'b0;
         end else begin
            // Output must hold without a request last cycle
            assert (data_out == last_data)
               else report_failure($sformatf("[ERROR] data_out got %h expected %h",
                                             data_out, last_data));
         end
         last_data = data_out;
         if (rx_ring_wptr[ring_ptr_width-1]) begin
            wrap_seen = 1'b1;
         end
         if (reads_allowed && rd_ptr != rx_ring_wptr) begin
            rd_address = rd_ptr[ring_addr_width-1:0];
            dma_rdreq  = 1'b1;
            rd_ptr     = rd_ptr + 1'b1;
            pending    = 1'b1;
         end else begin
            // Idle address differs from the last one read
            rd_address = rd_ptr[ring_addr_width-1:0];
            dma_rdreq  = 1'b0;
         end
      end
   end

   // Watchdog sized from the longest stream
   initial begin
      #watchdog_ns;
      $display("Timeout, the reader did not reach its word count in time");
      $display("Testbench failed");
      $fatal(1, "Timeout");
   end

   // Reset and test sequence
   initial begin
      data_in       = '0;
      rd_address    = '0;
      dma_rdreq     = 1'b0;
      enable_sfp    = 1'b1;
      xcvr_rx_ready = 1'b1;
      rst_n         = 1'b0;
      lfsr_state    = lfsr_seed;
      block_cnt     = 0;
      inject_start  = 32'h7fff_0000;
      reads_allowed = 1'b1;
      resync        = 1'b0;
      have_prev     = 1'b0;
      wrap_seen     = 1'b0;
      pending       = 1'b0;
      prev_idx      = 0;
      jump_count    = 0;
      words_read    = 0;
      rd_ptr        = '0;
      last_data     = '0;
      // Junk ahead of the first block boundary
      for (int i = 0; i < junk_bits; i++) begin
         stream_bits.push_back(take_bit());
      end
      repeat (4) @(posedge wr_clock);
      #1;
      rst_n = 1'b1;

      // Too few blocks for lock yet
      repeat (100) @(posedge wr_clock);
      #1;
      assert (rx_ring_wptr == '0)
         else report_failure($sformatf("[ERROR] rx_ring_wptr got %h expected %h",
                                       rx_ring_wptr, 9'h000));

      // Link disable gap
      wait (words_read >= 40);
      resync        = 1'b1;
      reads_allowed = 1'b0;
      #50;
      @(posedge wr_clock);
      #1;
      enable_sfp = 1'b0;
      repeat (10) @(posedge wr_clock);
      #1;
      frozen_wptr = rx_ring_wptr;
      repeat (150) @(posedge wr_clock);
      #1;
      assert (rx_ring_wptr == frozen_wptr)
         else report_failure($sformatf("[ERROR] rx_ring_wptr got %h expected %h",
                                       rx_ring_wptr, frozen_wptr));
      enable_sfp = 1'b1;
      #100;
      reads_allowed = 1'b1;

      // Bad header burst forces a lock loss
      wait (words_read >= 200);
      resync       = 1'b1;
      inject_start = block_cnt + 4;

      // Enough words to pass the pointer wrap
      wait (words_read >= 600);
      @(posedge wr_clock);
      #1;
      if (jump_count != 2 || !wrap_seen) begin
         $display("Stream gaps seen %0d instead of 2, or pointer wrap missing (%0d)",
                  jump_count, wrap_seen);
         $display("Testbench failed");
         $fatal(1, "Sequence check");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: sonic_rx_chan_properties.sv
// Concurrent checks on ring write gating and write pointer steps, bound into the ring
`timescale 1ns/1ps
`default_nettype none

module sonic_rx_chan_properties
   import sonic_pkg::*;
(
   input wire                      wr_clock,
   input wire                      rd_clock,
   input wire                      rst_n,
   input wire                      block_valid,
   input wire                      block_lock,
   input wire                      wr_enable,
   input wire                      half_full,
   input wire [ring_ptr_width-1:0] wptr_bin,
   input wire [ring_ptr_width-1:0] rx_ring_wptr
);

   // Pointer steps only on a completed pair, locked and enabled
   assert property (@(posedge wr_clock) disable iff (!rst_n)
      (wptr_bin != $past(wptr_bin)) |->
         $past(block_valid && block_lock && wr_enable && half_full))
      else $error("write pointer moved without a locked, enabled pair");

   // One step per clock at most, both domains
   assert property (@(posedge wr_clock) disable iff (!rst_n)
      (wptr_bin == $past(wptr_bin)) || (wptr_bin == $past(wptr_bin) + 1'b1))
      else $error("write pointer jumped by more than one");

   assert property (@(posedge rd_clock) disable iff (!rst_n)
      (rx_ring_wptr == $past(rx_ring_wptr)) || (rx_ring_wptr == $past(rx_ring_wptr) + 1'b1))
      else $error("rx_ring_wptr jumped by more than one");

   // Zero right out of reset
   assert property (@(posedge wr_clock) $rose(rst_n) |-> (wptr_bin == '0))
      else $error("write pointer not zero after reset");

   assert property (@(posedge rd_clock) $rose(rst_n) |-> (rx_ring_wptr == '0))
      else $error("rx_ring_wptr not zero after reset");

endmodule

bind sonic_rx_ring sonic_rx_chan_properties props (
   .wr_clock     (wr_clock),
   .rd_clock     (rd_clock),
   .rst_n        (rst_n),
   .block_valid  (block_valid),
   .block_lock   (block_lock),
   .wr_enable    (wr_enable),
   .half_full    (half_full),
   .wptr_bin     (wptr_bin),
   .rx_ring_wptr (rx_ring_wptr)
);

`default_nettype wire

// File: sonic_rx_chan_66.sv
// Receive channel top with gearbox, block sync and ring buffer
`timescale 1ns/1ps
`default_nettype none

module sonic_rx_chan_66
   import sonic_pkg::*;
(
   input  wire  [xcvr_width-1:0]      data_in,
   input  wire                        wr_clock,
   input  wire                        rd_clock,
   input  wire                        rst_n,
   input  wire  [ring_addr_width-1:0] rd_address,
   input  wire                        enable_sfp,
   input  wire                        xcvr_rx_ready,
   input  wire                        dma_rdreq,
   output logic [ring_width-1:0]      data_out,
   output logic [ring_ptr_width-1:0]  rx_ring_wptr
);

   // Gearbox to block sync
   logic [block_width-1:0]   gearbox_data;
   logic                     gearbox_valid;

   // Block sync to ring
   logic [payload_width-1:0] block_payload;
   logic                     block_valid;
   logic                     block_lock;

   // 40-bit transceiver words into 66-bit blocks
   sonic_gearbox_40_66 gearbox (
      .wr_clock      (wr_clock),
      .rst_n         (rst_n),
      .data_in       (data_in),
      .gearbox_data  (gearbox_data),
      .gearbox_valid (gearbox_valid)
   );

   // Boundary search and lock
   sonic_blocksync blocksync (
      .wr_clock      (wr_clock),
      .rst_n         (rst_n),
      .gearbox_data  (gearbox_data),
      .gearbox_valid (gearbox_valid),
      .block_payload (block_payload),
      .block_valid   (block_valid),
      .block_lock    (block_lock)
   );

   // Ring buffer read by DMA on rd_clock
   sonic_rx_ring rx_cbuf (
      .wr_clock      (wr_clock),
      .rd_clock      (rd_clock),
      .rst_n         (rst_n),
      .block_payload (block_payload),
      .block_valid   (block_valid),
      .block_lock    (block_lock),
      .enable_sfp    (enable_sfp),
      .xcvr_rx_ready (xcvr_rx_ready),
      .rd_address    (rd_address),
      .dma_rdreq     (dma_rdreq),
      .data_out      (data_out),
      .rx_ring_wptr  (rx_ring_wptr)
   );

endmodule

`default_nettype wire

// File: sonic_rx_ring.sv
// Payload pairing, dual-clock ring memory and Gray-coded write pointer crossing
`timescale 1ns/1ps
`default_nettype none

module sonic_rx_ring
   import sonic_pkg::*;
(
   input  wire                        wr_clock,
   input  wire                        rd_clock,
   input  wire                        rst_n,
   input  wire  [payload_width-1:0]   block_payload,
   input  wire                        block_valid,
   input  wire                        block_lock,
   input  wire                        enable_sfp,
   input  wire                        xcvr_rx_ready,
   input  wire  [ring_addr_width-1:0] rd_address,
   input  wire                        dma_rdreq,
   output logic [ring_width-1:0]      data_out,
   output logic [ring_ptr_width-1:0]  rx_ring_wptr
);

   // Enable synchronizers, bit 1 enable_sfp, bit 0 xcvr_rx_ready
   logic [sync_stages-1:0][1:0] wr_en_pipe;
   logic [sync_stages-1:0][1:0] rd_en_pipe;
   logic                        wr_enable;
   logic                        rd_enable;

   // Pairing state
   logic                        accept;
   logic                        half_full;
   logic [payload_width-1:0]    low_half;

   logic [ring_width-1:0]       ring_mem [ring_words];

   // Write pointer, binary for addressing and Gray for crossing
   logic [ring_ptr_width-1:0]   wptr_bin;
   logic [ring_ptr_width-1:0]   wptr_bin_next;
   logic [ring_ptr_width-1:0]   wptr_gray;
   logic [sync_stages-1:0][ring_ptr_width-1:0] wptr_gray_pipe;

   function automatic logic [ring_ptr_width-1:0] gray_to_bin(
      input logic [ring_ptr_width-1:0] gray
   );
      logic [ring_ptr_width-1:0] bin;
      bin[ring_ptr_width-1] = gray[ring_ptr_width-1];
      for (int i = ring_ptr_width - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // Both enables must be up on the synchronized side
   assign wr_enable     = &wr_en_pipe[sync_stages-1];
   assign rd_enable     = &rd_en_pipe[sync_stages-1];
   assign accept        = block_valid & block_lock & wr_enable;
   assign wptr_bin_next = wptr_bin + 1'b1;

   // Write side control
   always_ff @(posedge wr_clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_en_pipe <= '0;
         half_full  <= 1'b0;
         wptr_bin   <= '0;
         wptr_gray  <= '0;
      end else begin
         wr_en_pipe <= {wr_en_pipe[sync_stages-2:0], enable_sfp, xcvr_rx_ready};
         if (accept) begin
            half_full <= ~half_full;
            if (half_full) begin
               // Word completes, pointer moves with the write
               wptr_bin  <= wptr_bin_next;
               wptr_gray <= wptr_bin_next ^ (wptr_bin_next >> 1);
            end
         end else if (!block_lock || !wr_enable) begin
            // Lost lock or disabled link, half word is stale
            half_full <= 1'b0;
         end
      end
   end

   // Pair assembly and memory write, earlier payload in the low half
   always_ff @(posedge wr_clock) begin
      if (accept) begin
         if (half_full) begin
            ring_mem[wptr_bin[ring_addr_width-1:0]] <= {block_payload, low_half};
         end else begin
            low_half <= block_payload;
         end
      end
   end

   // Read side, pointer crossing and registered read
   always_ff @(posedge rd_clock or negedge rst_n) begin
      if (!rst_n) begin
         rd_en_pipe     <= '0;
         wptr_gray_pipe <= '0;
         rx_ring_wptr   <= '0;
         data_out       <= '0;
      end else begin
         rd_en_pipe     <= {rd_en_pipe[sync_stages-2:0], enable_sfp, xcvr_rx_ready};
         wptr_gray_pipe <= {wptr_gray_pipe[sync_stages-2:0], wptr_gray};
         // One more stage after the synchronizer
         rx_ring_wptr   <= gray_to_bin(wptr_gray_pipe[sync_stages-1]);
         if (dma_rdreq && rd_enable) begin
            data_out <= ring_mem[rd_address];
         end
      end
   end

   // No back-pressure, old words get overwritten
   // Reader watches rx_ring_wptr to stay ahead of the wrap

endmodule

`default_nettype wire

// File: sonic_blocksync.sv
// Block boundary search by sync header check and slip, with lock/hunt FSM
`timescale 1ns/1ps
`default_nettype none

module sonic_blocksync
   import sonic_pkg::*;
(
   input  wire                       wr_clock,
   input  wire                       rst_n,
   input  wire  [block_width-1:0]    gearbox_data,
   input  wire                       gearbox_valid,
   output logic [payload_width-1:0]  block_payload,
   output logic                      block_valid,
   output logic                      block_lock
);

   typedef enum logic {
      st_hunt,
      st_lock
   } sync_state_t;

   sync_state_t state;

   // Previous gearbox word, current one is gearbox_data
   logic [block_width-1:0]        last_word;
   logic [2*block_width-1:0]      word_pair;
   // Candidate block at the current bit offset
   logic [block_width-1:0]        window;
   logic [block_offset_width-1:0] offset;
   logic                          header_ok;

   // Consecutive good headers while hunting
   logic [good_cnt_width-1:0]     good_cnt;
   // Headers and bad headers in the current window while locked
   logic [window_cnt_width-1:0]   window_cnt;
   logic [bad_cnt_width-1:0]      bad_cnt;

   always_comb begin
      // Older bits sit low, later stream bits above
      word_pair = {gearbox_data, last_word};
      window    = block_width'(word_pair >> offset);
      // Header 01 or 10, i.e. the two bits differ
      header_ok = window[0] ^ window[1];
   end

   // Block data path, one block per gearbox strobe
   always_ff @(posedge wr_clock) begin
      if (gearbox_valid) begin
         last_word     <= gearbox_data;
         // Header stripped, payload kept
         block_payload <= window[block_width-1:2];
      end
   end

   // Lock/hunt FSM
   always_ff @(posedge wr_clock or negedge rst_n) begin
      if (!rst_n) begin
         state       <= st_hunt;
         offset      <= '0;
         good_cnt    <= '0;
         window_cnt  <= '0;
         bad_cnt     <= '0;
         block_valid <= 1'b0;
      end else begin
         block_valid <= gearbox_valid;
         if (gearbox_valid) begin
            case (state)
               st_hunt: begin
                  if (!header_ok) begin
                     // Slip one bit and start counting again
                     good_cnt <= '0;
                     offset   <= (offset == offset_max) ? '0 : offset + 1'b1;
                  end else if (good_cnt == good_cnt_max) begin
                     good_cnt   <= '0;
                     window_cnt <= '0;
                     bad_cnt    <= '0;
                     state      <= st_lock;
                  end else begin
                     good_cnt <= good_cnt + 1'b1;
                  end
               end
               st_lock: begin
                  if (!header_ok && (bad_cnt == bad_cnt_max)) begin
                     // Too many bad headers in this window
                     window_cnt <= '0;
                     bad_cnt    <= '0;
                     state      <= st_hunt;
                  end else if (window_cnt == window_cnt_max) begin
                     // Window closes, start a fresh one
                     window_cnt <= '0;
                     bad_cnt    <= '0;
                  end else begin
                     window_cnt <= window_cnt + 1'b1;
                     if (!header_ok) begin
                        bad_cnt <= bad_cnt + 1'b1;
                     end
                  end
               end
               default: state <= st_hunt;
            endcase
         end
      end
   end

   // Lock level lines up with the payload it was decided on
   assign block_lock = (state == st_lock);

endmodule

`default_nettype wire

// File: sonic_gearbox_40_66.sv
// 40-to-66 bit gearbox with residue buffer and block strobe
`timescale 1ns/1ps
`default_nettype none

module sonic_gearbox_40_66
   import sonic_pkg::*;
(
   input  wire                     wr_clock,
   input  wire                     rst_n,
   input  wire  [xcvr_width-1:0]   data_in,
   output logic [block_width-1:0]  gearbox_data,
   output logic                    gearbox_valid
);

   // Leftover bits, oldest at bit 0
   logic [gb_residue_width-1:0] residue;
   // Number of valid bits in residue, always below 66
   logic [gb_fill_width-1:0]    fill;

   // Residue with the new word stacked on top
   logic [gb_residue_width-1:0] merged;
   logic [gb_fill_width-1:0]    fill_sum;
   // A whole block is present this cycle
   logic                        block_ready;

   always_comb begin
      // New word lands right above the valid residue bits
      merged = residue |
               ({{(gb_residue_width - xcvr_width){1'b0}}, data_in} << fill);
      fill_sum    = fill + gb_fill_step;
      block_ready = (fill_sum >= gb_fill_block);
   end

   // Residue and fill bookkeeping
   always_ff @(posedge wr_clock or negedge rst_n) begin
      if (!rst_n) begin
         residue       <= '0;
         fill          <= '0;
         gearbox_valid <= 1'b0;
      end else begin
         // Strobe one cycle after 66 bits are first available
         gearbox_valid <= block_ready;
         if (block_ready) begin
            // Drop the emitted block, zeros fill from the top
            residue <= merged >> block_width;
            fill    <= fill_sum - gb_fill_block;
         end else begin
            residue <= merged;
            fill    <= fill_sum;
         end
      end
   end

   // Oldest 66 bits form the outgoing block
   always_ff @(posedge wr_clock) begin
      if (block_ready) begin
         gearbox_data <= merged[block_width-1:0];
      end
   end

   // 33 words in, 20 blocks out, one block per cycle at most
   // since 40 new bits never cover two blocks

endmodule

`default_nettype wire

// File: sonic_pkg.sv
// Link widths, block lock thresholds, gearbox and ring buffer geometry
`default_nettype none

package sonic_pkg;

   // Transceiver word and 64b/66b block widths
   localparam int xcvr_width    = 40;
   localparam int block_width   = 66;
   localparam int payload_width = 64;

   // Ring word carries two payloads
   localparam int ring_width      = 128;
   localparam int ring_addr_width = 8;
   localparam int ring_ptr_width  = 9;
   localparam int ring_words      = 2 ** ring_addr_width;

   // Lock acquisition and loss thresholds, in headers
   localparam int lock_good_count  = 64;
   localparam int unlock_window    = 64;
   localparam int unlock_bad_count = 16;

   // Flops per clock domain crossing
   localparam int sync_stages = 2;

   // Gearbox residue holds one new word over at most 65 leftover bits
   localparam int gb_residue_width = xcvr_width + block_width - 1;
   localparam int gb_fill_width    = $clog2(gb_residue_width + 1);
   localparam logic [gb_fill_width-1:0] gb_fill_step  = gb_fill_width'(xcvr_width);
   localparam logic [gb_fill_width-1:0] gb_fill_block = gb_fill_width'(block_width);

   // Block alignment offset, 0 to 65
   localparam int block_offset_width = $clog2(block_width);
   localparam logic [block_offset_width-1:0] offset_max = block_offset_width'(block_width - 1);

   // Counter widths and terminal values for the lock FSM
   localparam int good_cnt_width   = $clog2(lock_good_count);
   localparam int window_cnt_width = $clog2(unlock_window);
   localparam int bad_cnt_width    = $clog2(unlock_bad_count);
   localparam logic [good_cnt_width-1:0]   good_cnt_max   = good_cnt_width'(lock_good_count - 1);
   localparam logic [window_cnt_width-1:0] window_cnt_max = window_cnt_width'(unlock_window - 1);
   localparam logic [bad_cnt_width-1:0]    bad_cnt_max    = bad_cnt_width'(unlock_bad_count - 1);

endpackage

`default_nettype wire
